/* Makefile */
VERILATOR ?= verilator
TOP ?= tb_ring_bus
FLIST ?= tb.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary

SRCS := $(shell grep '\.sv$$' $(FLIST))
BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(BUILD_DIR) -o V$(TOP)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi
	@if ! grep -q "RESULT: PASS" $(LOG); then \
		echo "simulation ended without a result, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* design/apb_node_host.sv */
`timescale 1ns/1ps

module apb_node_host
	import bus_proto_pkg::*;
	import host_regs_pkg::*;
(
	input logic CLK,
	input logic RESET,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [4:0] paddr,
	input data_t pwdata,
	output data_t prdata,
	output logic pready,
	node_host_if.host node
);

	logic busy;
	logic succ;
	logic fail;
	logic rx_valid;
	logic wr_access;
	logic rd_setup;
	logic rd_access;
	logic rx_take;
	addr_t rx_addr_q;
	data_t rx_data_q;
	data_t status;

	assign wr_access = psel & penable & pwrite;
	assign rd_setup = psel & ~penable & ~pwrite;
	assign rd_access = psel & penable & ~pwrite;
	assign rx_take = node.rx_req & ~rx_valid & ~node.rx_ack;

	always_comb
	begin
		status = '0;
		status[ST_BUSY] = busy;
		status[ST_SUCC] = succ;
		status[ST_FAIL] = fail;
		status[ST_RX_VALID] = rx_valid;
	end

	always_ff @(posedge CLK)
	begin
		if (wr_access && (paddr == REG_TX_ADDR))
			node.tx_addr <= pwdata[ADDR_WIDTH-1:0];
		if (wr_access && (paddr == REG_TX_DATA))
			node.tx_data <= pwdata;
		if (rx_take)
		begin
			rx_addr_q <= node.rx_addr;
			rx_data_q <= node.rx_data;
		end
	end

	always_ff @(posedge CLK or negedge RESET)
	begin
		if (!RESET)
		begin
			busy <= 1'b0;
			succ <= 1'b0;
			fail <= 1'b0;
			rx_valid <= 1'b0;
			node.tx_req <= 1'b0;
			node.tx_resp_ack <= 1'b0;
			node.rx_ack <= 1'b0;
			pready <= 1'b0;
			prdata <= '0;
		end
		else
		begin
			// no wait states
			pready <= psel & ~penable;

			if (node.tx_req & node.tx_ack)
				node.tx_req <= 1'b0;
			if (wr_access && (paddr == REG_TX_DATA))
			begin
				node.tx_req <= 1'b1;
				busy <= 1'b1;
			end

			if (wr_access && (paddr == REG_STATUS))
			begin
				succ <= 1'b0;
				fail <= 1'b0;
			end

			// one pulse per response
			node.tx_resp_ack <= (node.tx_succ | node.tx_fail) & ~node.tx_resp_ack;
			if ((node.tx_succ | node.tx_fail) && !node.tx_resp_ack)
			begin
				busy <= 1'b0;
				if (node.tx_succ)
					succ <= 1'b1;
				if (node.tx_fail)
					fail <= 1'b1;
			end

			if (rx_take)
				rx_valid <= 1'b1;
			if (node.rx_ack & ~node.rx_req)
				node.rx_ack <= 1'b0;
			if (rd_access && (paddr == REG_RX_DATA) && rx_valid)
			begin
				rx_valid <= 1'b0;
				node.rx_ack <= 1'b1;
			end

			if (rd_setup)
			begin
				case (paddr)
					REG_TX_ADDR: prdata <= data_t'(node.tx_addr);
					REG_TX_DATA: prdata <= node.tx_data;
					REG_STATUS: prdata <= status;
					REG_RX_ADDR: prdata <= data_t'(rx_addr_q);
					REG_RX_DATA: prdata <= rx_data_q;
					default: prdata <= '0;
				endcase
			end
		end
	end

endmodule

/* design/bit_counter.sv */
`timescale 1ns/1ps

module bit_counter
	import bus_proto_pkg::*;
(
	input logic CLK,
	input logic RESET,
	input bus_state_t state,
	input logic field_start,
	output logic [BIT_POS_WIDTH-1:0] bit_pos,
	output logic field_end,
	output logic addr_done,
	output logic hold_done
);

	logic [HOLD_WIDTH-1:0] hold_cnt;

	always_ff @(posedge CLK or negedge RESET)
	begin
		if (!RESET)
		begin
			bit_pos <= BIT_POS_WIDTH'(ADDR_WIDTH - 1);
			addr_done <= 1'b0;
			hold_cnt <= HOLD_WIDTH'(RESET_HOLD - 1);
		end
		else
		begin
			if (field_start)
			begin
				bit_pos <= BIT_POS_WIDTH'(ADDR_WIDTH - 1);
				addr_done <= 1'b0;
			end
			else if (state == latch2)
			begin
				if (bit_pos != '0)
					bit_pos <= bit_pos - 1'b1;
				else if (!addr_done)
				begin
					// address finished, data word follows
					bit_pos <= BIT_POS_WIDTH'(DATA_WIDTH - 1);
					addr_done <= 1'b1;
				end
			end

			// bus_reset is only entered from latch2
			if (state == latch2)
				hold_cnt <= HOLD_WIDTH'(RESET_HOLD - 1);
			else if ((state == bus_reset) && (hold_cnt != '0))
				hold_cnt <= hold_cnt - 1'b1;
		end
	end

	assign field_end = (bit_pos == '0);
	assign hold_done = (state == bus_reset) && (hold_cnt == '0);

endmodule

/* design/bus_phase_ctrl.sv */
`timescale 1ns/1ps

module bus_phase_ctrl
	import bus_proto_pkg::*;
#(
	parameter addr_t ADDRESS = 8'h00,
	parameter addr_t ADDRESS_MASK = 8'hff
)
(
	input logic CLK,
	input logic RESET,
	input logic din,
	input logic field_end,
	input logic addr_done,
	input logic hold_done,
	input logic addr_msb,
	input logic data_msb,
	input addr_t rx_addr,
	input logic ring_head,
	output bus_state_t state,
	output logic dout,
	output logic load,
	output logic shift_addr,
	output logic shift_data,
	output logic field_start,
	output logic bus_idle,
	node_host_if.node host
);

	node_mode_t mode;
	logic overflow;
	logic in_sample;
	logic claimed;
	logic dout_q;
	logic ring_out;
	logic toggle;
	logic addr_match;
	logic last_bit;
	logic leave_idle;
	logic win;
	logic rx_signal;
	logic moves_bits;

	assign last_bit = field_end & addr_done;
	// latch1 sample against the live ring in latch2
	assign toggle = in_sample ^ din;
	assign addr_match = ((rx_addr ^ ADDRESS) & ADDRESS_MASK) == '0;
	assign leave_idle = ~dout | ~din;
	// head sees its own pull one cycle late through dout_q
	assign win = ring_head ? claimed : (host.tx_req & din);
	assign rx_signal = (mode == rx) & (overflow | last_bit);
	assign moves_bits = (mode == tx) | (mode == rx);

	assign bus_idle = (state == bus_proto_pkg::bus_idle);
	assign load = bus_idle & leave_idle & win;
	assign field_start = (state == arbi_resolved);
	assign shift_addr = (state == latch1) & ~addr_done & moves_bits;
	assign shift_data = (state == latch1) & addr_done & moves_bits;

	always_comb
	begin
		ring_out = din;
		case (state)
			bus_proto_pkg::bus_idle:
				ring_out = ~host.tx_req & din;
			arbi_resolved:
			begin
				if (mode == tx)
					ring_out = 1'b0;
			end
			drive1, latch1:
			begin
				if (mode == tx)
					ring_out = addr_done ? data_msb : addr_msb;
			end
			drive2, latch2:
			begin
				// ack or interrupt by toggling the ring
				if (rx_signal)
					ring_out = ~in_sample;
			end
			bus_reset:
				ring_out = 1'b1;
			default:
				ring_out = din;
		endcase
	end

	assign dout = ring_head ? dout_q : ring_out;

	always_ff @(posedge CLK or negedge RESET)
	begin
		if (!RESET)
		begin
			state <= bus_proto_pkg::bus_idle;
			mode <= idle;
			overflow <= 1'b0;
			in_sample <= 1'b0;
			claimed <= 1'b0;
			dout_q <= 1'b1;
			host.tx_ack <= 1'b0;
			host.tx_succ <= 1'b0;
			host.tx_fail <= 1'b0;
			host.rx_req <= 1'b0;
		end
		else
		begin
			dout_q <= ring_out;
			claimed <= bus_idle & host.tx_req & din;

			if (host.tx_ack & ~host.tx_req)
				host.tx_ack <= 1'b0;
			if (host.rx_req & host.rx_ack)
				host.rx_req <= 1'b0;
			if (host.tx_resp_ack)
			begin
				host.tx_succ <= 1'b0;
				host.tx_fail <= 1'b0;
			end

			case (state)
				bus_proto_pkg::bus_idle:
				begin
					if (leave_idle)
					begin
						state <= arbi_resolved;
						overflow <= 1'b0;
						if (win)
						begin
							mode <= tx;
							host.tx_ack <= 1'b1;
						end
						else
							mode <= rx;
					end
				end
				arbi_resolved:
					state <= drive1;
				drive1:
					state <= latch1;
				latch1:
				begin
					in_sample <= din;
					state <= drive2;
				end
				drive2:
					state <= latch2;
				latch2:
				begin
					if (last_bit)
					begin
						state <= bus_reset;
						if (mode == tx)
						begin
							if (toggle)
								host.tx_succ <= 1'b1;
							else
								host.tx_fail <= 1'b1;
						end
						if ((mode == rx) && !overflow)
							host.rx_req <= 1'b1;
					end
					else if (toggle)
					begin
						// interrupted by a receiver
						state <= bus_reset;
						if (mode == tx)
							host.tx_fail <= 1'b1;
					end
					else
					begin
						state <= drive1;
						// end of address field
						if (field_end && (mode == rx))
						begin
							if (!addr_match)
								mode <= fwd;
							else if (host.rx_req | host.rx_ack)
								overflow <= 1'b1;
						end
					end
				end
				bus_reset:
				begin
					if (hold_done)
					begin
						state <= bus_proto_pkg::bus_idle;
						mode <= idle;
					end
				end
				default:
					state <= bus_proto_pkg::bus_idle;
			endcase
		end
	end

endmodule

/* design/bus_proto_pkg.sv */
package bus_proto_pkg;

	localparam int ADDR_WIDTH = 8;
	localparam int DATA_WIDTH = 32;

	// cycles spent in bus_reset before the ring returns to idle
	localparam int RESET_HOLD = 4;

	localparam int BIT_POS_WIDTH = 5;
	localparam int HOLD_WIDTH = $clog2(RESET_HOLD);

	typedef logic [ADDR_WIDTH-1:0] addr_t;
	typedef logic [DATA_WIDTH-1:0] data_t;

	typedef enum logic [2:0] {
		bus_idle,
		arbi_resolved,
		drive1,
		latch1,
		drive2,
		latch2,
		bus_reset
	} bus_state_t;

	typedef enum logic [1:0] {
		idle,
		tx,
		rx,
		fwd
	} node_mode_t;

endpackage

/* design/host_regs_pkg.sv */
package host_regs_pkg;

	// byte offsets on the 5-bit APB address
	localparam logic [4:0] REG_TX_ADDR = 5'h00;
	localparam logic [4:0] REG_TX_DATA = 5'h04;
	localparam logic [4:0] REG_STATUS = 5'h08;
	localparam logic [4:0] REG_RX_ADDR = 5'h0C;
	localparam logic [4:0] REG_RX_DATA = 5'h10;

	// status register bits
	localparam int ST_BUSY = 0;
	localparam int ST_SUCC = 1;
	localparam int ST_FAIL = 2;
	localparam int ST_RX_VALID = 3;

endpackage

/* design/node_host_if.sv */
`timescale 1ns/1ps

interface node_host_if
	import bus_proto_pkg::*;
();

	// transmit request, host to node
	addr_t tx_addr;
	data_t tx_data;
	logic tx_req;
	logic tx_ack;

	// transmit response
	logic tx_succ;
	logic tx_fail;
	logic tx_resp_ack;

	// receive buffer, node to host
	addr_t rx_addr;
	data_t rx_data;
	logic rx_req;
	logic rx_ack;

	modport node (
		input tx_addr, tx_data, tx_req, tx_resp_ack, rx_ack,
		output tx_ack, tx_succ, tx_fail, rx_addr, rx_data, rx_req
	);

	modport host (
		output tx_addr, tx_data, tx_req, tx_resp_ack, rx_ack,
		input tx_ack, tx_succ, tx_fail, rx_addr, rx_data, rx_req
	);

endinterface

/* design/ring_bus_top.sv */
`timescale 1ns/1ps

module ring_bus_top (
	input logic CLK,
	input logic RESET,
	input logic [4:0] paddr,
	input logic pwrite,
	input logic [31:0] pwdata,
	input logic penable,
	input logic psel0,
	input logic psel1,
	output logic [31:0] prdata0,
	output logic [31:0] prdata1,
	output logic pready0,
	output logic pready1,
	output logic bus_idle0,
	output logic bus_idle1
);

	logic ring0;
	logic ring1;

	node_host_if if0 ();
	node_host_if if1 ();

	apb_node_host u_host0 (
		.CLK(CLK), .RESET(RESET),
		.psel(psel0), .penable(penable), .pwrite(pwrite),
		.paddr(paddr), .pwdata(pwdata),
		.prdata(prdata0), .pready(pready0),
		.node(if0.host)
	);

	apb_node_host u_host1 (
		.CLK(CLK), .RESET(RESET),
		.psel(psel1), .penable(penable), .pwrite(pwrite),
		.paddr(paddr), .pwdata(pwdata),
		.prdata(prdata1), .pready(pready1),
		.node(if1.host)
	);

	// node0 holds the ring register
	ring_node #(.ADDRESS(8'h21), .ADDRESS_MASK(8'hff), .RING_HEAD(1'b1)) u_node0 (
		.CLK(CLK), .RESET(RESET),
		.din(ring1), .dout(ring0),
		.bus_idle(bus_idle0), .host(if0.node)
	);

	ring_node #(.ADDRESS(8'h42), .ADDRESS_MASK(8'hff), .RING_HEAD(1'b0)) u_node1 (
		.CLK(CLK), .RESET(RESET),
		.din(ring0), .dout(ring1),
		.bus_idle(bus_idle1), .host(if1.node)
	);

endmodule

/* design/ring_node.sv */
`timescale 1ns/1ps

module ring_node
	import bus_proto_pkg::*;
#(
	parameter addr_t ADDRESS = 8'h00,
	parameter addr_t ADDRESS_MASK = 8'hff,
	parameter bit RING_HEAD = 1'b0
)
(
	input logic CLK,
	input logic RESET,
	input logic din,
	output logic dout,
	output logic bus_idle,
	node_host_if.node host
);

	bus_state_t state;
	logic field_end;
	logic addr_done;
	logic hold_done;
	logic field_start;
	logic load;
	logic shift_addr;
	logic shift_data;
	logic addr_msb;
	logic data_msb;
	addr_t addr_value;
	data_t data_value;

	bus_phase_ctrl #(
		.ADDRESS(ADDRESS),
		.ADDRESS_MASK(ADDRESS_MASK)
	) u_ctrl (
		.CLK(CLK),
		.RESET(RESET),
		.din(din),
		.field_end(field_end),
		.addr_done(addr_done),
		.hold_done(hold_done),
		.addr_msb(addr_msb),
		.data_msb(data_msb),
		.rx_addr(addr_value),
		.ring_head(RING_HEAD),
		.state(state),
		.dout(dout),
		.load(load),
		.shift_addr(shift_addr),
		.shift_data(shift_data),
		.field_start(field_start),
		.bus_idle(bus_idle),
		.host(host)
	);

	bit_counter u_counter (
		.CLK(CLK),
		.RESET(RESET),
		.state(state),
		.field_start(field_start),
		.bit_pos(),
		.field_end(field_end),
		.addr_done(addr_done),
		.hold_done(hold_done)
	);

	// shared by transmit and receive
	word_shifter #(.payload_t(addr_t)) u_addr_sh (
		.CLK(CLK),
		.RESET(RESET),
		.load(load),
		.load_value(host.tx_addr),
		.shift(shift_addr),
		.serial_in(din),
		.value(addr_value),
		.msb(addr_msb)
	);

	word_shifter #(.payload_t(data_t)) u_data_sh (
		.CLK(CLK),
		.RESET(RESET),
		.load(load),
		.load_value(host.tx_data),
		.shift(shift_data),
		.serial_in(din),
		.value(data_value),
		.msb(data_msb)
	);

	assign host.rx_addr = addr_value;
	assign host.rx_data = data_value;

endmodule

/* design/word_shifter.sv */
`timescale 1ns/1ps

module word_shifter #(
	parameter type payload_t = logic [7:0]
)
(
	input logic CLK,
	input logic RESET,
	input logic load,
	input payload_t load_value,
	input logic shift,
	input logic serial_in,
	output payload_t value,
	output logic msb
);

	localparam int WIDTH = $bits(payload_t);

	always_ff @(posedge CLK or negedge RESET)
	begin
		if (!RESET)
			value <= payload_t'(0);
		else if (load)
			value <= load_value;
		else if (shift)
			value <= payload_t'({value[WIDTH-2:0], serial_in});
	end

	// bit on the ring while transmitting
	assign msb = value[WIDTH-1];

endmodule

/* tb.f */
design/bus_proto_pkg.sv
design/host_regs_pkg.sv
design/node_host_if.sv
design/bit_counter.sv
design/word_shifter.sv
design/bus_phase_ctrl.sv
design/ring_node.sv
design/apb_node_host.sv
design/ring_bus_top.sv
verification/tb_ring_bus.sv

/* verification/tb_ring_bus.sv */
`timescale 1ns/1ps

module tb_ring_bus
	import bus_proto_pkg::*;
	import host_regs_pkg::*;
();

	localparam addr_t NODE0_ADDR = 8'h21;
	localparam addr_t NODE1_ADDR = 8'h42;
	localparam int NUM_MSGS = 17;
	// 200 cycles per message, plus a margin for reset and register-only tests
	localparam int CYCLE_LIMIT = 200 * NUM_MSGS + 100;

	logic CLK;
	logic RESET;
	logic [4:0] paddr;
	logic pwrite;
	logic [31:0] pwdata;
	logic penable;
	logic psel0;
	logic psel1;
	logic [31:0] prdata0;
	logic [31:0] prdata1;
	logic pready0;
	logic pready1;
	logic bus_idle0;
	logic bus_idle1;

	logic [31:0] seed = 32'h13c8;
	int cycles = 0;
	string cur_test;
	int test_errs;
	int tests_passed = 0;
	int tests_failed = 0;

	// reference model, one entry per node
	logic m_succ [0:1];
	logic m_fail [0:1];
	logic m_rx_valid [0:1];
	addr_t m_rx_addr [0:1];
	data_t m_rx_data [0:1];

	ring_bus_top dut (
		.CLK(CLK), .RESET(RESET),
		.paddr(paddr), .pwrite(pwrite), .pwdata(pwdata), .penable(penable),
		.psel0(psel0), .psel1(psel1),
		.prdata0(prdata0), .prdata1(prdata1),
		.pready0(pready0), .pready1(pready1),
		.bus_idle0(bus_idle0), .bus_idle1(bus_idle1)
	);

	always #50 CLK = ~CLK;

	always @(posedge CLK)
	begin
		cycles++;
		if (cycles >= CYCLE_LIMIT)
		begin
			$display("timeout after %0d cycles in test %s", cycles, cur_test);
			$display("RESULT: FAIL");
			$finish;
		end
	end

	function logic [31:0] next_rand();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed;
	endfunction

	function logic [31:0] expected_status(input bit n);
		logic [31:0] s;
		s = '0;
		s[ST_SUCC] = m_succ[n];
		s[ST_FAIL] = m_fail[n];
		s[ST_RX_VALID] = m_rx_valid[n];
		return s;
	endfunction

	// pready is low in setup and high in the access phase
	task check_ready(input bit n, input logic exp);
		logic rdy;
		rdy = n ? pready1 : pready0;
		if (rdy !== exp)
			report_value($sformatf("pready of node%0d", n), {31'h0, exp}, {31'h0, rdy});
	endtask

	// tasks start and end 5 ns after a rising edge
	task apb_write(input bit n, input logic [4:0] a, input logic [31:0] d);
		psel0 = (n == 1'b0);
		psel1 = (n == 1'b1);
		paddr = a;
		pwrite = 1'b1;
		pwdata = d;
		penable = 1'b0;
		check_ready(n, 1'b0);
		@(posedge CLK);
		#5 penable = 1'b1;
		check_ready(n, 1'b1);
		@(posedge CLK);
		#5;
		psel0 = 1'b0;
		psel1 = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
	endtask

	task apb_read(input bit n, input logic [4:0] a, output logic [31:0] d);
		psel0 = (n == 1'b0);
		psel1 = (n == 1'b1);
		paddr = a;
		pwrite = 1'b0;
		penable = 1'b0;
		check_ready(n, 1'b0);
		@(posedge CLK);
		#5 penable = 1'b1;
		d = n ? prdata1 : prdata0;
		check_ready(n, 1'b1);
		@(posedge CLK);
		#5;
		psel0 = 1'b0;
		psel1 = 1'b0;
		penable = 1'b0;
	endtask

	task report_value(input string what, input logic [31:0] exp, input logic [31:0] act);
		$display("Fail %s %s: expected %h, actual %h", cur_test, what, exp, act);
		test_errs++;
	endtask

	task begin_test(input string name);
		cur_test = name;
		test_errs = 0;
	endtask

	task end_test();
		if (test_errs == 0)
		begin
			$display("%s: passed", cur_test);
			tests_passed++;
		end
		else
		begin
			$display("%s: failed with %0d errors", cur_test, test_errs);
			tests_failed++;
		end
	endtask

	task check_status(input bit n);
		logic [31:0] got;
		logic [31:0] exp;
		exp = expected_status(n);
		apb_read(n, REG_STATUS, got);
		if (got !== exp)
			report_value($sformatf("status of node%0d", n), exp, got);
	endtask

	task clear_status(input bit n);
		apb_write(n, REG_STATUS, 32'h0);
		m_succ[n] = 1'b0;
		m_fail[n] = 1'b0;
	endtask

	// reads the rx buffer out, which also releases it
	task check_receive(input bit n);
		logic [31:0] got;
		check_status(n);
		apb_read(n, REG_RX_ADDR, got);
		if (got !== {24'h0, m_rx_addr[n]})
			report_value($sformatf("rx_addr of node%0d", n), {24'h0, m_rx_addr[n]}, got);
		apb_read(n, REG_RX_DATA, got);
		if (got !== m_rx_data[n])
			report_value($sformatf("rx_data of node%0d", n), m_rx_data[n], got);
		m_rx_valid[n] = 1'b0;
		check_status(n);
	endtask

	task send_msg(input bit src, input addr_t dst, input data_t word);
		logic [31:0] st;
		bit tgt;
		bit hit;
		apb_write(src, REG_TX_ADDR, {24'h0, dst});
		apb_write(src, REG_TX_DATA, word);
		do
			apb_read(src, REG_STATUS, st);
		while (st[ST_BUSY]);
		while (!(bus_idle0 && bus_idle1))
		begin
			@(posedge CLK);
			#5;
		end
		tgt = ~src;
		hit = (src == 1'b0) ? (dst == NODE1_ADDR) : (dst == NODE0_ADDR);
		// a full rx buffer interrupts the message
		if (hit && !m_rx_valid[tgt])
		begin
			m_succ[src] = 1'b1;
			m_rx_valid[tgt] = 1'b1;
			m_rx_addr[tgt] = dst;
			m_rx_data[tgt] = word;
		end
		else
			m_fail[src] = 1'b1;
	endtask

	initial
	begin
		logic [31:0] r;
		addr_t a;
		bit src;
		CLK = 1'b0;
		RESET = 1'b0;
		paddr = '0;
		pwrite = 1'b0;
		pwdata = '0;
		penable = 1'b0;
		psel0 = 1'b0;
		psel1 = 1'b0;
		for (int n = 0; n < 2; n++)
		begin
			m_succ[n] = 1'b0;
			m_fail[n] = 1'b0;
			m_rx_valid[n] = 1'b0;
			m_rx_addr[n] = '0;
			m_rx_data[n] = '0;
		end
		repeat (3) @(posedge CLK);
		#5 RESET = 1'b1;

		begin_test("reset_state");
		check_status(1'b0);
		check_status(1'b1);
		if (!(bus_idle0 && bus_idle1))
		begin
			$display("%s: a node is not idle after reset", cur_test);
			test_errs++;
		end
		end_test();

		begin_test("delivery");
		send_msg(1'b0, NODE1_ADDR, next_rand());
		check_status(1'b0);
		check_receive(1'b1);
		end_test();

		begin_test("alternating");
		for (int i = 0; i < 12; i++)
		begin
			src = i[0];
			send_msg(src, src ? NODE0_ADDR : NODE1_ADDR, next_rand());
			check_status(src);
			check_receive(~src);
		end
		end_test();

		begin_test("unmatched_address");
		r = next_rand();
		a = r[7:0];
		if ((a == NODE0_ADDR) || (a == NODE1_ADDR))
			a = a ^ 8'h80;
		send_msg(1'b0, a, next_rand());
		check_status(1'b0);
		check_status(1'b1);
		end_test();

		begin_test("overflow");
		clear_status(1'b0);
		send_msg(1'b0, NODE1_ADDR, next_rand());
		check_status(1'b0);
		send_msg(1'b0, NODE1_ADDR, next_rand());
		check_status(1'b0);
		check_receive(1'b1);
		end_test();

		begin_test("status_clear");
		clear_status(1'b0);
		clear_status(1'b1);
		check_status(1'b0);
		check_status(1'b1);
		send_msg(1'b1, NODE0_ADDR, next_rand());
		check_status(1'b1);
		check_receive(1'b0);
		end_test();

		$display("%0d tests passed, %0d tests failed", tests_passed, tests_failed);
		if (tests_failed == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule
